/* source/rvv_dispatch_pkg.sv */
//--------------------------------------------------
// dispatch package: vector constants, encodings
// and the uop records passed between dispatch blocks
//--------------------------------------------------
package rvv_dispatch_pkg;

    // vector register geometry
    localparam int VLEN            = 128;
    localparam int VLENB           = VLEN / 8;
    localparam int VL_WIDTH        = 8;
    localparam int VSTART_WIDTH    = 7;
    localparam int UOP_INDEX_WIDTH = 3;

    typedef enum logic [2:0] {
        EEW_NONE = 3'd0,
        EEW1     = 3'd1,
        EEW8     = 3'd2,
        EEW16    = 3'd3,
        EEW32    = 3'd4
    } eew_e;

    typedef enum logic {
        ALU = 1'b0,
        RDT = 1'b1
    } exe_unit_e;

    // per byte view of an operand for the processing and retire side
    typedef enum logic [1:0] {
        NOT_CHANGE    = 2'd0,
        BODY_ACTIVE   = 2'd1,
        BODY_INACTIVE = 2'd2,
        TAIL          = 2'd3
    } byte_type_e;

    typedef enum logic [1:0] {
        SPLIT_IDLE  = 2'd0,
        SPLIT_ISSUE = 2'd1,
        SPLIT_WAIT  = 2'd2
    } split_state_e;

    typedef struct packed {
        eew_e                         vs1_eew;
        eew_e                         vs2_eew;
        eew_e                         vd_eew;
        logic                         vm;
        logic                         ignore_vta;
        logic                         ignore_vma;
        logic [VL_WIDTH-1:0]          vl;
        logic [VSTART_WIDTH-1:0]      vstart;
        exe_unit_e                    exe_unit;
        logic [UOP_INDEX_WIDTH-1:0]   uop_num;
    } inst_info_t;

    typedef struct packed {
        inst_info_t                   inst;
        logic [UOP_INDEX_WIDTH-1:0]   uop_index;
        logic                         uop_last;
    } uop_info_t;

    typedef struct packed {
        byte_type_e [VLENB-1:0]       vs1;
        byte_type_e [VLENB-1:0]       vs2;
        byte_type_e [VLENB-1:0]       vd;
    } opn_byte_type_t;

    typedef struct packed {
        logic                         valid;
        uop_info_t                    uop;
        opn_byte_type_t               byte_type;
    } lane_out_t;

endpackage

/* source/rvv_dispatch_uop_split.sv */
//--------------------------------------------------
// uop splitter: holds one instruction and issues
// its uops to the lanes, NUM_LANES per group
//--------------------------------------------------
module rvv_dispatch_uop_split #(
    parameter int NUM_LANES = 4
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          inst_valid,
    input  rvv_dispatch_pkg::inst_info_t                  inst_info,
    input  logic [rvv_dispatch_pkg::VLEN-1:0]             v0_enable,
    input  logic                                          group_taken,
    output logic                                          inst_ready,
    output logic                                          group_issue,
    output logic [NUM_LANES-1:0]                          lane_valid,
    output rvv_dispatch_pkg::uop_info_t [NUM_LANES-1:0]   lane_uop,
    output logic [rvv_dispatch_pkg::VLEN-1:0]             lane_v0
);

    localparam int IDX_W  = rvv_dispatch_pkg::UOP_INDEX_WIDTH;
    localparam int WIDE_W = IDX_W + 1;

    rvv_dispatch_pkg::split_state_e                state_q;
    rvv_dispatch_pkg::split_state_e                state_d;
    rvv_dispatch_pkg::inst_info_t                  inst_q;
    logic [IDX_W-1:0]                              base_q;
    logic                                          group_last_q;
    logic                                          accept;
    logic                                          issue_now;
    logic [NUM_LANES-1:0]                          issue_valid;
    logic                                          issue_has_last;
    rvv_dispatch_pkg::uop_info_t [NUM_LANES-1:0]   issue_uop;

    assign accept    = inst_valid && inst_ready;
    // first ISSUE cycle loads the group, second one carries group_issue
    assign issue_now = (state_q == rvv_dispatch_pkg::SPLIT_ISSUE) && !group_issue;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rvv_dispatch_pkg::SPLIT_IDLE: begin
                if (accept) begin
                    state_d = rvv_dispatch_pkg::SPLIT_ISSUE;
                end
            end
            rvv_dispatch_pkg::SPLIT_ISSUE: begin
                if (group_issue) begin
                    state_d = rvv_dispatch_pkg::SPLIT_WAIT;
                end
            end
            rvv_dispatch_pkg::SPLIT_WAIT: begin
                if (group_taken) begin
                    state_d = group_last_q ? rvv_dispatch_pkg::SPLIT_IDLE
                                           : rvv_dispatch_pkg::SPLIT_ISSUE;
                end
            end
            default: state_d = rvv_dispatch_pkg::SPLIT_IDLE;
        endcase
    end

    // lane k of the group carries uop base+k
    always_comb begin
        logic [WIDE_W-1:0] idx;
        issue_has_last = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx                    = {1'b0, base_q} + WIDE_W'(k);
            issue_valid[k]         = idx <= {1'b0, inst_q.uop_num};
            issue_uop[k].inst      = inst_q;
            issue_uop[k].uop_index = idx[IDX_W-1:0];
            issue_uop[k].uop_last  = idx == {1'b0, inst_q.uop_num};
            issue_has_last         = issue_has_last | issue_uop[k].uop_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= rvv_dispatch_pkg::SPLIT_IDLE;
            inst_ready   <= 1'b0;
            group_issue  <= 1'b0;
            lane_valid   <= '0;
            base_q       <= '0;
            group_last_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            inst_ready  <= state_d == rvv_dispatch_pkg::SPLIT_IDLE;
            group_issue <= issue_now;
            if (issue_now) begin
                lane_valid   <= issue_valid;
                group_last_q <= issue_has_last;
            end else if (group_taken) begin
                lane_valid <= '0;
            end
            if (accept) begin
                base_q <= '0;
            end else if (group_taken) begin
                base_q <= base_q + IDX_W'(NUM_LANES);
            end
        end
    end

    // held instruction, v0 and lane payload
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q  <= inst_info;
            lane_v0 <= v0_enable;
        end
        if (issue_now) begin
            lane_uop <= issue_uop;
        end
    end

    a_no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) inst_valid |-> inst_ready);

    a_no_issue_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        state_q == rvv_dispatch_pkg::SPLIT_WAIT |-> !group_issue);

endmodule

/* source/rvv_dispatch_opr_byte_type.sv */
//--------------------------------------------------
// dispatch lane: classifies every byte of vs1, vs2
// and vd for one uop and registers the result
//--------------------------------------------------
module rvv_dispatch_opr_byte_type (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              uop_valid,
    input  rvv_dispatch_pkg::uop_info_t       uop_info,
    input  logic [rvv_dispatch_pkg::VLEN-1:0] v0_enable,
    output rvv_dispatch_pkg::lane_out_t       lane_out
);

    localparam int VLENB       = rvv_dispatch_pkg::VLENB;
    localparam int VLENB_WIDTH = $clog2(VLENB);
    localparam int V0_WIDTH    = $clog2(rvv_dispatch_pkg::VLEN);
    localparam int ELE_W       = rvv_dispatch_pkg::VL_WIDTH;

    // operand slot 0 is vs1, 1 is vs2, 2 is vd
    logic [2:0][1:0]                                  opn_shift;
    logic [1:0]                                       eew_max_shift;
    logic [2:0][ELE_W-1:0]                            opn_start;
    logic [ELE_W-1:0]                                 vd_end;
    logic                                             vd_narrow;
    rvv_dispatch_pkg::byte_type_e [2:0][VLENB-1:0]    opn_type;
    rvv_dispatch_pkg::opn_byte_type_t                 byte_type;

    logic                                             out_valid;
    rvv_dispatch_pkg::uop_info_t                      out_uop;
    rvv_dispatch_pkg::opn_byte_type_t                 out_type;

    // EEW1 and EEW_NONE count as byte elements
    function automatic logic [1:0] eew_shift(input rvv_dispatch_pkg::eew_e eew);
        case (eew)
            rvv_dispatch_pkg::EEW16: return 2'd1;
            rvv_dispatch_pkg::EEW32: return 2'd2;
            default:                 return 2'd0;
        endcase
    endfunction

    assign opn_shift[0] = eew_shift(uop_info.inst.vs1_eew);
    assign opn_shift[1] = eew_shift(uop_info.inst.vs2_eew);
    assign opn_shift[2] = eew_shift(uop_info.inst.vd_eew);

    // widest operand sets the element count of a uop
    always_comb begin
        eew_max_shift = opn_shift[0];
        for (int k = 1; k < 3; k++) begin
            if (opn_shift[k] > eew_max_shift) begin
                eew_max_shift = opn_shift[k];
            end
        end
    end

    // narrower operands share one register among 2 or 4 uops
    always_comb begin
        logic [1:0] ratio;
        for (int k = 0; k < 3; k++) begin
            ratio        = eew_max_shift - opn_shift[k];
            opn_start[k] = ELE_W'(uop_info.uop_index >> ratio)
                           << (VLENB_WIDTH - opn_shift[k]);
        end
    end

    // narrowing vd: an even uop fills the low half, an odd one the high half
    assign vd_narrow = (eew_max_shift - opn_shift[2]) == 2'd1;
    assign vd_end    = opn_start[2]
                     + ((ELE_W'(VLENB) >> eew_max_shift) << uop_info.uop_index[0])
                     - 1'b1;

    always_comb begin
        logic [ELE_W-1:0] ele_index;
        logic             mask_bit;
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < VLENB; i++) begin
                ele_index = opn_start[k] + ELE_W'(i >> opn_shift[k]);
                mask_bit  = uop_info.inst.vm || uop_info.inst.ignore_vma ||
                            v0_enable[ele_index[V0_WIDTH-1:0]];
                if (uop_info.inst.ignore_vta && uop_info.inst.ignore_vma) begin
                    opn_type[k][i] = rvv_dispatch_pkg::BODY_ACTIVE;
                end else if (ele_index >= uop_info.inst.vl) begin
                    opn_type[k][i] = rvv_dispatch_pkg::TAIL;
                end else if (ele_index < {1'b0, uop_info.inst.vstart}) begin
                    // prestart
                    opn_type[k][i] = rvv_dispatch_pkg::NOT_CHANGE;
                end else if (k == 2 && vd_narrow && ele_index > vd_end) begin
                    opn_type[k][i] = rvv_dispatch_pkg::BODY_INACTIVE;
                end else begin
                    opn_type[k][i] = mask_bit ? rvv_dispatch_pkg::BODY_ACTIVE
                                              : rvv_dispatch_pkg::BODY_INACTIVE;
                end
                // reduction result is one element at the bottom of vd
                if (k == 2 && uop_info.inst.exe_unit == rvv_dispatch_pkg::RDT) begin
                    opn_type[k][i] = (i >> opn_shift[2]) == 0 ? rvv_dispatch_pkg::BODY_ACTIVE
                                                              : rvv_dispatch_pkg::TAIL;
                end
            end
        end
        byte_type.vs1 = opn_type[0];
        byte_type.vs2 = opn_type[1];
        byte_type.vd  = opn_type[2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            out_uop  <= uop_info;
            out_type <= byte_type;
        end
    end

    assign lane_out = {out_valid, out_uop, out_type};

    a_valid_follows_input: assert property (
        @(posedge clk) disable iff (!rst_n) !uop_valid |=> !lane_out.valid);

endmodule

/* source/rvv_dispatch_uop_serialize.sv */
//--------------------------------------------------
// uop serializer: takes a classified group from the
// lanes and emits its valid uops one per cycle
//--------------------------------------------------
module rvv_dispatch_uop_serialize #(
    parameter int NUM_LANES = 4
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  rvv_dispatch_pkg::lane_out_t [NUM_LANES-1:0]   lane_out,
    output logic                                          group_taken,
    output logic                                          uop_valid,
    output rvv_dispatch_pkg::uop_info_t                   uop_info,
    output rvv_dispatch_pkg::opn_byte_type_t              operand_byte_type
);

    localparam int PTR_W = NUM_LANES > 1 ? $clog2(NUM_LANES) : 1;

    rvv_dispatch_pkg::lane_out_t [NUM_LANES-1:0]   grp_q;
    logic [NUM_LANES-1:0]                          in_valid;
    logic                                          busy_q;
    logic [PTR_W-1:0]                              ptr_q;
    logic [PTR_W-1:0]                              last_q;
    logic [PTR_W-1:0]                              last_d;

    // highest valid lane ends the group
    always_comb begin
        last_d = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            in_valid[k] = lane_out[k].valid;
            if (lane_out[k].valid) begin
                last_d = PTR_W'(k);
            end
        end
    end

    // load only into an empty buffer
    assign group_taken = !busy_q && |in_valid;

    assign uop_valid         = busy_q && grp_q[ptr_q].valid;
    assign uop_info          = grp_q[ptr_q].uop;
    assign operand_byte_type = grp_q[ptr_q].byte_type;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            ptr_q  <= '0;
            last_q <= '0;
        end else if (group_taken) begin
            busy_q <= 1'b1;
            ptr_q  <= '0;
            last_q <= last_d;
        end else if (busy_q) begin
            if (ptr_q == last_q) begin
                busy_q <= 1'b0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (group_taken) begin
            grp_q <= lane_out;
        end
    end

    // splitter fills lanes from lane 0 up without holes
    a_contiguous_group: assert property (
        @(posedge clk) disable iff (!rst_n)
        group_taken |-> in_valid[0] && ((in_valid & (in_valid + 1'b1)) == '0));

endmodule

/* source/rvv_dispatch_top.sv */
//--------------------------------------------------
// dispatch byte type stage: splitter, lane array
// and serializer
//--------------------------------------------------
module rvv_dispatch_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              inst_valid,
    input  rvv_dispatch_pkg::inst_info_t      inst_info,
    input  logic [rvv_dispatch_pkg::VLEN-1:0] v0_enable,
    output logic                              inst_ready,
    output logic                              uop_valid,
    output rvv_dispatch_pkg::uop_info_t       uop_info,
    output rvv_dispatch_pkg::opn_byte_type_t  operand_byte_type
);

    logic                                          group_issue;
    logic                                          group_taken;
    logic [NUM_LANES-1:0]                          lane_valid;
    rvv_dispatch_pkg::uop_info_t [NUM_LANES-1:0]   lane_uop;
    logic [rvv_dispatch_pkg::VLEN-1:0]             lane_v0;
    rvv_dispatch_pkg::lane_out_t [NUM_LANES-1:0]   lane_out;

    rvv_dispatch_uop_split #(
        .NUM_LANES (NUM_LANES)
    ) u_split (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst_info   (inst_info),
        .v0_enable   (v0_enable),
        .group_taken (group_taken),
        .inst_ready  (inst_ready),
        .group_issue (group_issue),
        .lane_valid  (lane_valid),
        .lane_uop    (lane_uop),
        .lane_v0     (lane_v0)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
        rvv_dispatch_opr_byte_type u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .uop_valid (lane_valid[k]),
            .uop_info  (lane_uop[k]),
            .v0_enable (lane_v0),
            .lane_out  (lane_out[k])
        );
    end

    rvv_dispatch_uop_serialize #(
        .NUM_LANES (NUM_LANES)
    ) u_serialize (
        .clk               (clk),
        .rst_n             (rst_n),
        .lane_out          (lane_out),
        .group_taken       (group_taken),
        .uop_valid         (uop_valid),
        .uop_info          (uop_info),
        .operand_byte_type (operand_byte_type)
    );

    // every issued group holds at least uop base in lane 0
    a_issue_reaches_lane: assert property (
        @(posedge clk) disable iff (!rst_n) group_issue |=> lane_out[0].valid);

endmodule

/* verif/rvv_dispatch_tb_model.svh */
//--------------------------------------------------
// reference model for the expected byte types of one uop
//--------------------------------------------------
`ifndef RVV_DISPATCH_TB_MODEL_SVH
`define RVV_DISPATCH_TB_MODEL_SVH

// log2 of the element size in bytes
function automatic int elem_log2(input rvv_dispatch_pkg::eew_e eew);
    int res;
    res = 0;
    if (eew == rvv_dispatch_pkg::EEW16) begin
        res = 1;
    end else if (eew == rvv_dispatch_pkg::EEW32) begin
        res = 2;
    end
    return res;
endfunction

// class of byte i for an operand with elements of 1 << sh bytes
function automatic rvv_dispatch_pkg::byte_type_e byte_class(
    input rvv_dispatch_pkg::inst_info_t      inst,
    input int                                uop_index,
    input logic [rvv_dispatch_pkg::VLEN-1:0] v0,
    input int                                sh,
    input int                                sh_max,
    input bit                                narrow_vd,
    input int                                i
);
    int first;
    int elem;
    int half_end;
    first    = (uop_index >> (sh_max - sh)) * (rvv_dispatch_pkg::VLENB >> sh);
    elem     = first + (i >> sh);
    // even uops own the low half of a narrowed vd, odd uops reach into the high half
    half_end = first + (rvv_dispatch_pkg::VLENB >> sh_max) * (uop_index % 2 + 1);
    if (inst.ignore_vta && inst.ignore_vma) begin
        return rvv_dispatch_pkg::BODY_ACTIVE;
    end
    if (elem >= int'(inst.vl)) begin
        return rvv_dispatch_pkg::TAIL;
    end
    if (elem < int'(inst.vstart)) begin
        return rvv_dispatch_pkg::NOT_CHANGE;
    end
    if (narrow_vd && elem >= half_end) begin
        return rvv_dispatch_pkg::BODY_INACTIVE;
    end
    if (inst.vm || inst.ignore_vma || v0[elem]) begin
        return rvv_dispatch_pkg::BODY_ACTIVE;
    end
    return rvv_dispatch_pkg::BODY_INACTIVE;
endfunction

function automatic rvv_dispatch_pkg::opn_byte_type_t expected_byte_types(
    input rvv_dispatch_pkg::inst_info_t      inst,
    input int                                uop_index,
    input logic [rvv_dispatch_pkg::VLEN-1:0] v0
);
    rvv_dispatch_pkg::opn_byte_type_t res;
    int sh1;
    int sh2;
    int shd;
    int shm;
    sh1 = elem_log2(inst.vs1_eew);
    sh2 = elem_log2(inst.vs2_eew);
    shd = elem_log2(inst.vd_eew);
    shm = sh1 > sh2 ? sh1 : sh2;
    shm = shd > shm ? shd : shm;
    for (int i = 0; i < rvv_dispatch_pkg::VLENB; i++) begin
        res.vs1[i] = byte_class(inst, uop_index, v0, sh1, shm, 1'b0, i);
        res.vs2[i] = byte_class(inst, uop_index, v0, sh2, shm, 1'b0, i);
        if (inst.exe_unit == rvv_dispatch_pkg::RDT) begin
            // one result element at the bottom of vd
            res.vd[i] = i < (1 << shd) ? rvv_dispatch_pkg::BODY_ACTIVE
                                       : rvv_dispatch_pkg::TAIL;
        end else begin
            res.vd[i] = byte_class(inst, uop_index, v0, shd, shm, shm - shd == 1, i);
        end
    end
    return res;
endfunction

`endif

/* verif/rvv_dispatch_tb.sv */
//--------------------------------------------------
// testbench for the dispatch byte type stage
//--------------------------------------------------
module rvv_dispatch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int VLEN = rvv_dispatch_pkg::VLEN;
    localparam rvv_dispatch_pkg::eew_e      EN    = rvv_dispatch_pkg::EEW_NONE;
    localparam rvv_dispatch_pkg::eew_e      E1    = rvv_dispatch_pkg::EEW1;
    localparam rvv_dispatch_pkg::eew_e      E8    = rvv_dispatch_pkg::EEW8;
    localparam rvv_dispatch_pkg::eew_e      E16   = rvv_dispatch_pkg::EEW16;
    localparam rvv_dispatch_pkg::eew_e      E32   = rvv_dispatch_pkg::EEW32;
    localparam rvv_dispatch_pkg::exe_unit_e U_ALU = rvv_dispatch_pkg::ALU;
    localparam rvv_dispatch_pkg::exe_unit_e U_RDT = rvv_dispatch_pkg::RDT;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic                             inst_valid;
    rvv_dispatch_pkg::inst_info_t     inst_info;
    logic [VLEN-1:0]                  v0_enable;
    logic                             inst_ready;
    logic                             uop_valid;
    rvv_dispatch_pkg::uop_info_t      uop_info;
    rvv_dispatch_pkg::opn_byte_type_t operand_byte_type;

    // stimulus table with one entry per instruction
    string                            row_name[$];
    rvv_dispatch_pkg::inst_info_t     row_inst[$];
    int                               row_v0_sel[$];
    int                               row_uops[$];

    // uops the DUT still owes in issue order
    string                            exp_name_q[$];
    rvv_dispatch_pkg::uop_info_t      exp_uop_q[$];
    rvv_dispatch_pkg::opn_byte_type_t exp_type_q[$];

    logic [31:0]                      rng_state;
    int                               cycle_count;
    int                               timeout_limit;

    `include "rvv_dispatch_tb_model.svh"

    rvv_dispatch_top #(
        .NUM_LANES (4)
    ) DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_valid        (inst_valid),
        .inst_info         (inst_info),
        .v0_enable         (v0_enable),
        .inst_ready        (inst_ready),
        .uop_valid         (uop_valid),
        .uop_info          (uop_info),
        .operand_byte_type (operand_byte_type)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift_next(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            fail_run("control flag mismatch");
        end
    endtask

    task automatic check_uop_info(input string name, input rvv_dispatch_pkg::uop_info_t exp,
                                  input rvv_dispatch_pkg::uop_info_t act);
        if (act !== exp) begin
            $display("Error: %s uop info expected %h actual %h", name, exp, act);
            fail_run("uop info mismatch");
        end
    endtask

    task automatic check_byte_type(input string name,
                                   input rvv_dispatch_pkg::opn_byte_type_t exp,
                                   input rvv_dispatch_pkg::opn_byte_type_t act);
        if (act !== exp) begin
            $display("Error: %s byte types expected %h actual %h", name, exp, act);
            fail_run("operand byte type mismatch");
        end
    endtask

    // flags are {vm, ignore_vta, ignore_vma}
    task automatic add_row(input string name, input rvv_dispatch_pkg::eew_e vs1,
                           input rvv_dispatch_pkg::eew_e vs2, input rvv_dispatch_pkg::eew_e vd,
                           input logic [2:0] flags, input int vl, input int vstart,
                           input rvv_dispatch_pkg::exe_unit_e unit, input int uop_num,
                           input int v0_sel, input int n_uops);
        rvv_dispatch_pkg::inst_info_t inst;
        inst.vs1_eew = vs1;
        inst.vs2_eew = vs2;
        inst.vd_eew  = vd;
        {inst.vm, inst.ignore_vta, inst.ignore_vma} = flags;
        inst.vl       = vl[rvv_dispatch_pkg::VL_WIDTH-1:0];
        inst.vstart   = vstart[rvv_dispatch_pkg::VSTART_WIDTH-1:0];
        inst.exe_unit = unit;
        inst.uop_num  = uop_num[rvv_dispatch_pkg::UOP_INDEX_WIDTH-1:0];
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_v0_sel.push_back(v0_sel);
        row_uops.push_back(n_uops);
    endtask

    task automatic fill_table();
        // v0 selector 0 is all zeros, 1 all ones, 2 random
        //      name             vs1  vs2  vd   flags   vl   vst unit   num v0 uops
        add_row("alu_e8_vm",     E8,  E8,  E8,  3'b100, 40,  0,  U_ALU, 2,  0, 3);
        add_row("alu_e32_vm",    E32, E32, E32, 3'b100, 10,  0,  U_ALU, 3,  0, 4);
        add_row("masked_e16",    E16, E16, E16, 3'b000, 30,  0,  U_ALU, 3,  2, 4);
        add_row("masked_vma_e1", E1,  E8,  E8,  3'b001, 20,  0,  U_ALU, 1,  2, 2);
        add_row("agnostic_both", E8,  E8,  E8,  3'b011, 5,   0,  U_ALU, 1,  2, 2);
        add_row("vstart_e8",     E8,  E8,  E8,  3'b000, 45,  21, U_ALU, 2,  2, 3);
        add_row("vstart_e32",    E32, E32, E32, 3'b100, 12,  6,  U_ALU, 3,  1, 4);
        add_row("widen_2to1",    E8,  E8,  E16, 3'b000, 28,  3,  U_ALU, 3,  2, 4);
        add_row("widen_4to1",    E8,  E8,  E32, 3'b100, 27,  0,  U_ALU, 7,  0, 8);
        add_row("narrow_vd",     E8,  E16, E8,  3'b000, 25,  0,  U_ALU, 3,  2, 4);
        add_row("reduce_e32",    EN,  E32, E32, 3'b100, 20,  0,  U_RDT, 1,  0, 2);
        add_row("reduce_e16",    E16, E16, E16, 3'b000, 8,   0,  U_RDT, 0,  2, 1);
        add_row("reduce_e8",     E8,  E8,  E8,  3'b011, 50,  0,  U_RDT, 3,  2, 4);
        add_row("two_groups_a",  E8,  E8,  E8,  3'b000, 100, 0,  U_ALU, 6,  2, 7);
        add_row("two_groups_b",  E16, E16, E16, 3'b100, 50,  2,  U_ALU, 6,  0, 7);
    endtask

    task automatic make_v0(input int sel, output logic [VLEN-1:0] v0);
        v0 = '0;
        if (sel == 1) begin
            v0 = '1;
        end else if (sel == 2) begin
            for (int w = 0; w < VLEN / 32; w++) begin
                rng_state      = xorshift_next(rng_state);
                v0[w*32 +: 32] = rng_state;
            end
        end
    endtask

    // strobe one instruction once the splitter is idle and queue its uops
    task automatic send_inst(input int r);
        logic [VLEN-1:0]             v0;
        rvv_dispatch_pkg::uop_info_t uop;
        make_v0(row_v0_sel[r], v0);
        while (inst_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b1;
        inst_info  = row_inst[r];
        v0_enable  = v0;
        for (int u = 0; u < row_uops[r]; u++) begin
            uop.inst      = row_inst[r];
            uop.uop_index = u[rvv_dispatch_pkg::UOP_INDEX_WIDTH-1:0];
            uop.uop_last  = u == row_uops[r] - 1;
            exp_name_q.push_back($sformatf("%s uop %0d", row_name[r], u));
            exp_uop_q.push_back(uop);
            exp_type_q.push_back(expected_byte_types(row_inst[r], u, v0));
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        check_flag($sformatf("%s ready after accept", row_name[r]), 1'b0, inst_ready);
    endtask

    // compare each emitted uop with the oldest owed one
    always @(negedge clk) begin
        if (!rst_n) begin
            check_flag("uop_valid in reset", 1'b0, uop_valid);
        end else if (uop_valid === 1'b1) begin
            if (exp_uop_q.size() == 0) begin
                fail_run("a uop arrived that no accepted instruction still owed");
            end else begin
                check_uop_info(exp_name_q[0], exp_uop_q[0], uop_info);
                check_byte_type(exp_name_q[0], exp_type_q[0], operand_byte_type);
                void'(exp_name_q.pop_front());
                void'(exp_uop_q.pop_front());
                void'(exp_type_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            fail_run($sformatf("timeout after %0d cycles with %0d uops missing",
                               cycle_count, exp_uop_q.size()));
        end
    end

    initial begin
        rst_n         = 1'b0;
        inst_valid    = 1'b0;
        inst_info     = '0;
        v0_enable     = '0;
        rng_state     = 32'd77521;
        cycle_count   = 0;
        timeout_limit = 0;
        fill_table();
        foreach (row_inst[r]) begin
            timeout_limit += (int'(row_inst[r].uop_num) + 1) * 8 + 20;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("ready in first cycle", 1'b0, inst_ready);
        for (int r = 0; r < row_inst.size(); r++) begin
            send_inst(r);
        end
        while (exp_uop_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        #1;
        check_flag("ready when drained", 1'b1, inst_ready);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+verif
source/rvv_dispatch_pkg.sv
source/rvv_dispatch_uop_split.sv
source/rvv_dispatch_opr_byte_type.sv
source/rvv_dispatch_uop_serialize.sv
source/rvv_dispatch_top.sv
verif/rvv_dispatch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the dispatch testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module rvv_dispatch_tb -f list.f \
    && ./obj_dir/Vrvv_dispatch_tb | tee sim.log \
    && grep -q "TEST RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
